/* source/video_pkg.sv */
package video_pkg;

	// display geometry, in clock cycles and lines
	localparam int H_TOTAL    = 512;
	localparam int H_SYNC     = 8;
	localparam int H_PIX_BEG  = 16;
	localparam int H_ACTIVE   = 32;
	localparam int V_TOTAL    = 12;
	localparam int V_ACTIVE   = 8;
	localparam int V_SYNC_BEG = 10;

	// sprites and memory layout
	localparam int SPR_NUM      = 4;
	localparam int SPR_SIZE     = 8;
	localparam int LINE_WORDS   = 16;
	localparam int PAGE_WORDS   = 256;
	localparam int SPR_PIX_OFFS = 64;

	typedef logic [7:0]  pixel_t;
	typedef logic [20:0] dram_addr_t;
	typedef logic [15:0] dram_data_t;
	typedef logic [7:0]  page_t;
	typedef logic [4:0]  xcoord_t;
	typedef logic [8:0]  hcnt_t;
	typedef logic [3:0]  line_t;
	typedef logic [1:0]  cfg_addr_t;

	typedef struct packed {
		page_t  vpage;
		page_t  sgpage;
		pixel_t border;
	} cfg_t;

	typedef struct packed {
		logic    we;
		xcoord_t col;
		pixel_t  pix;
	} lb_wr_t;

	// descriptor word as stored in sprite page
	typedef struct packed {
		logic       en;
		logic [1:0] rsv_hi;
		logic [4:0] y;
		logic [2:0] rsv_lo;
		logic [4:0] x;
	} spr_desc_t;

	typedef enum logic [2:0] {F_IDLE, F_REQ, F_WAIT, F_WR_LO, F_WR_HI} fetch_state_t;

	typedef enum logic [2:0] {S_IDLE, S_DREQ, S_DWAIT, S_TEST, S_PREQ, S_PWAIT, S_WR} spr_state_t;

endpackage

/* source/video_ports.sv */
`timescale 1ns/1ns

module video_ports import video_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  logic      cfg_wr,
	input  cfg_addr_t cfg_addr,
	input  pixel_t    cfg_data,
	output cfg_t      cfg
);

	// register select decode
	always_ff @(posedge clk) begin
		if (reset) begin
			cfg <= '0;
		end else if (cfg_wr) begin
			case (cfg_addr)
				2'd0: begin
					cfg.vpage <= cfg_data;
				end
				2'd1: begin
					cfg.sgpage <= cfg_data;
				end
				2'd2: begin
					cfg.border <= cfg_data;
				end
				default: begin
					// address 3 is unused
					cfg <= cfg;
				end
			endcase
		end
	end

endmodule

/* source/video_sync.sv */
`timescale 1ns/1ns

module video_sync import video_pkg::*; (
	input  logic    clk,
	input  logic    reset,
	output logic    hsync,
	output logic    vsync,
	output logic    de,
	output xcoord_t col,
	output logic    line_start,
	output logic    render_start,
	output line_t   next_row
);

	hcnt_t hcount;
	line_t line;
	logic  h_last;
	logic  v_last;

	assign h_last = (hcount == hcnt_t'(H_TOTAL - 1));
	assign v_last = (line == line_t'(V_TOTAL - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			hcount <= '0;
			line <= '0;
		end else begin
			hcount <= h_last ? '0 : hcount + 1'b1;
			if (h_last) begin
				line <= v_last ? '0 : line + 1'b1;
			end
		end
	end

	// syncs are active high
	assign hsync = (hcount < hcnt_t'(H_SYNC));
	assign vsync = (line >= line_t'(V_SYNC_BEG));

	assign de = (hcount >= hcnt_t'(H_PIX_BEG))
		&& (hcount < hcnt_t'(H_PIX_BEG + H_ACTIVE))
		&& (line < line_t'(V_ACTIVE));
	assign col = xcoord_t'(hcount - hcnt_t'(H_PIX_BEG));

	assign line_start = (hcount == '0);

	// render one line ahead, last blank line prepares row 0
	assign render_start = line_start && (v_last || (line < line_t'(V_ACTIVE - 1)));
	assign next_row = v_last ? '0 : line + 1'b1;

endmodule

/* source/video_fetch.sv */
`timescale 1ns/1ns

module video_fetch import video_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       render_start,
	input  line_t      next_row,
	input  page_t      vpage,
	output logic       req,
	output dram_addr_t addr,
	input  logic       ack,
	input  dram_data_t rdata,
	output lb_wr_t     bm_wr
);

	fetch_state_t state;
	page_t        vpage_l;
	line_t        row_l;
	logic [3:0]   word;
	dram_data_t   data;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= F_IDLE;
			req <= 1'b0;
			vpage_l <= '0;
			row_l <= '0;
			word <= '0;
		end else begin
			case (state)
				F_IDLE: begin
					if (render_start) begin
						// page is taken fresh for every line
						vpage_l <= vpage;
						row_l <= next_row;
						word <= '0;
						state <= F_REQ;
					end
				end
				F_REQ: begin
					// previous handshake must be fully closed
					if (!ack) begin
						req <= 1'b1;
						state <= F_WAIT;
					end
				end
				F_WAIT: begin
					if (ack) begin
						req <= 1'b0;
						state <= F_WR_LO;
					end
				end
				F_WR_LO: begin
					state <= F_WR_HI;
				end
				F_WR_HI: begin
					if (word == 4'(LINE_WORDS - 1)) begin
						state <= F_IDLE;
					end else begin
						word <= word + 1'b1;
						state <= F_REQ;
					end
				end
				default: begin
					state <= F_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == F_WAIT && ack) begin
			data <= rdata;
		end
	end

	assign addr = dram_addr_t'(vpage_l * PAGE_WORDS + row_l * LINE_WORDS + word);

	// low byte is the left pixel
	assign bm_wr.we = (state == F_WR_LO) || (state == F_WR_HI);
	assign bm_wr.col = {word, state == F_WR_HI};
	assign bm_wr.pix = (state == F_WR_HI) ? data[15:8] : data[7:0];

endmodule

/* source/video_sprites.sv */
`timescale 1ns/1ns

module video_sprites import video_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       render_start,
	input  line_t      next_row,
	input  page_t      sgpage,
	output logic       req,
	output dram_addr_t addr,
	input  logic       ack,
	input  dram_data_t rdata,
	output lb_wr_t     sp_wr
);

	spr_state_t state;
	page_t      sgpage_l;
	line_t      row_l;
	logic [1:0] idx;
	logic [1:0] pword;
	logic       half;
	logic       last_idx;
	spr_desc_t  desc;
	dram_data_t data;
	logic [5:0] dy;
	logic [5:0] colx;
	logic       hit;
	pixel_t     pix;

	// row inside the sprite, negative offsets wrap high and miss
	assign dy = {2'b00, row_l} - {1'b0, desc.y};
	assign hit = desc.en && (dy < 6'(SPR_SIZE));
	assign last_idx = (idx == 2'(SPR_NUM - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= S_IDLE;
			req <= 1'b0;
			sgpage_l <= '0;
			row_l <= '0;
			idx <= '0;
			pword <= '0;
			half <= 1'b0;
		end else begin
			case (state)
				S_IDLE: begin
					if (render_start) begin
						sgpage_l <= sgpage;
						row_l <= next_row;
						idx <= '0;
						state <= S_DREQ;
					end
				end
				S_DREQ: begin
					if (!ack) begin
						req <= 1'b1;
						state <= S_DWAIT;
					end
				end
				S_DWAIT: begin
					if (ack) begin
						req <= 1'b0;
						state <= S_TEST;
					end
				end
				S_TEST: begin
					if (hit) begin
						pword <= '0;
						state <= S_PREQ;
					end else if (last_idx) begin
						state <= S_IDLE;
					end else begin
						idx <= idx + 1'b1;
						state <= S_DREQ;
					end
				end
				S_PREQ: begin
					if (!ack) begin
						req <= 1'b1;
						state <= S_PWAIT;
					end
				end
				S_PWAIT: begin
					if (ack) begin
						req <= 1'b0;
						half <= 1'b0;
						state <= S_WR;
					end
				end
				S_WR: begin
					half <= ~half;
					if (half) begin
						if (pword != 2'd3) begin
							pword <= pword + 1'b1;
							state <= S_PREQ;
						end else if (last_idx) begin
							state <= S_IDLE;
						end else begin
							idx <= idx + 1'b1;
							state <= S_DREQ;
						end
					end
				end
				default: begin
					state <= S_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == S_DWAIT && ack) begin
			desc <= spr_desc_t'(rdata);
		end
		if (state == S_PWAIT && ack) begin
			data <= rdata;
		end
	end

	// descriptors first, then 4 words per sprite row
	always_comb begin
		if (state == S_DREQ || state == S_DWAIT) begin
			addr = dram_addr_t'(sgpage_l * PAGE_WORDS + idx);
		end else begin
			addr = dram_addr_t'(sgpage_l * PAGE_WORDS + SPR_PIX_OFFS
				+ idx * SPR_SIZE * 4 + dy[2:0] * 4 + pword);
		end
	end

	assign pix = half ? data[15:8] : data[7:0];
	assign colx = {1'b0, desc.x} + {3'b000, pword, half};

	// zero is transparent, off-screen columns dropped
	assign sp_wr.we = (state == S_WR) && (pix != '0) && (colx < 6'(H_ACTIVE));
	assign sp_wr.col = colx[4:0];
	assign sp_wr.pix = pix;

endmodule

/* source/dram_arbiter.sv */
`timescale 1ns/1ns

module dram_arbiter import video_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       c0_req,
	input  dram_addr_t c0_addr,
	output logic       c0_ack,
	output dram_data_t c0_rdata,
	input  logic       c1_req,
	input  dram_addr_t c1_addr,
	output logic       c1_ack,
	output dram_data_t c1_rdata,
	output logic       dram_req,
	output dram_addr_t dram_addr,
	input  logic       dram_ack,
	input  dram_data_t dram_rdata
);

	// owner doubles as last served client when idle
	logic owner;
	logic active;
	logic owner_req;

	assign owner_req = owner ? c1_req : c0_req;

	always_ff @(posedge clk) begin
		if (reset) begin
			owner <= 1'b1;
			active <= 1'b0;
		end else if (!active) begin
			if (c0_req && c1_req) begin
				owner <= ~owner;
				active <= 1'b1;
			end else if (c0_req || c1_req) begin
				owner <= c1_req;
				active <= 1'b1;
			end
		end else if (!owner_req && !dram_ack) begin
			// handshake closed on both sides
			active <= 1'b0;
		end
	end

	assign dram_req = active && owner_req;
	assign dram_addr = owner ? c1_addr : c0_addr;

	assign c0_ack = active && !owner && dram_ack;
	assign c1_ack = active && owner && dram_ack;
	assign c0_rdata = dram_rdata;
	assign c1_rdata = dram_rdata;

endmodule

/* source/video_linebuf.sv */
`timescale 1ns/1ns

module video_linebuf import video_pkg::*; (
	input  logic    clk,
	input  logic    reset,
	input  logic    line_start,
	input  lb_wr_t  bm_wr,
	input  lb_wr_t  sp_wr,
	input  logic    de,
	input  xcoord_t col,
	input  pixel_t  border,
	output pixel_t  pixel
);

	pixel_t              bm_mem  [0:1][0:H_ACTIVE-1];
	pixel_t              spr_mem [0:1][0:H_ACTIVE-1];
	logic [H_ACTIVE-1:0] spr_valid [0:1];
	logic                wr_half;
	logic                rd_half;

	assign rd_half = ~wr_half;

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_half <= 1'b0;
			spr_valid[0] <= '0;
			spr_valid[1] <= '0;
		end else if (line_start) begin
			// displayed half becomes the render target
			wr_half <= ~wr_half;
			spr_valid[rd_half] <= '0;
		end else if (sp_wr.we) begin
			spr_valid[wr_half][sp_wr.col] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (bm_wr.we) begin
			bm_mem[wr_half][bm_wr.col] <= bm_wr.pix;
		end
		if (sp_wr.we) begin
			spr_mem[wr_half][sp_wr.col] <= sp_wr.pix;
		end
	end

	// sprite layer over bitmap, border outside active area
	always_ff @(posedge clk) begin
		if (!de) begin
			pixel <= border;
		end else if (spr_valid[rd_half][col]) begin
			pixel <= spr_mem[rd_half][col];
		end else begin
			pixel <= bm_mem[rd_half][col];
		end
	end

endmodule

/* source/video_top.sv */
`timescale 1ns/1ns

module video_top import video_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       cfg_wr,
	input  cfg_addr_t  cfg_addr,
	input  pixel_t     cfg_data,
	output logic       dram_req,
	output dram_addr_t dram_addr,
	input  logic       dram_ack,
	input  dram_data_t dram_rdata,
	output logic       hsync,
	output logic       vsync,
	output logic       pixel_de,
	output pixel_t     pixel
);

	cfg_t cfg;

	// sync strobes
	logic    de;
	xcoord_t col;
	logic    line_start;
	logic    render_start;
	line_t   next_row;

	// engine clients
	logic       bm_req;
	dram_addr_t bm_addr;
	logic       bm_ack;
	dram_data_t bm_rdata;
	logic       sp_req;
	dram_addr_t sp_addr;
	logic       sp_ack;
	dram_data_t sp_rdata;

	lb_wr_t bm_wr;
	lb_wr_t sp_wr;

	video_ports video_ports (
		.clk      (clk),
		.reset    (reset),
		.cfg_wr   (cfg_wr),
		.cfg_addr (cfg_addr),
		.cfg_data (cfg_data),
		.cfg      (cfg)
	);

	video_sync video_sync (
		.clk          (clk),
		.reset        (reset),
		.hsync        (hsync),
		.vsync        (vsync),
		.de           (de),
		.col          (col),
		.line_start   (line_start),
		.render_start (render_start),
		.next_row     (next_row)
	);

	video_fetch video_fetch (
		.clk          (clk),
		.reset        (reset),
		.render_start (render_start),
		.next_row     (next_row),
		.vpage        (cfg.vpage),
		.req          (bm_req),
		.addr         (bm_addr),
		.ack          (bm_ack),
		.rdata        (bm_rdata),
		.bm_wr        (bm_wr)
	);

	video_sprites video_sprites (
		.clk          (clk),
		.reset        (reset),
		.render_start (render_start),
		.next_row     (next_row),
		.sgpage       (cfg.sgpage),
		.req          (sp_req),
		.addr         (sp_addr),
		.ack          (sp_ack),
		.rdata        (sp_rdata),
		.sp_wr        (sp_wr)
	);

	dram_arbiter dram_arbiter (
		.clk        (clk),
		.reset      (reset),
		.c0_req     (bm_req),
		.c0_addr    (bm_addr),
		.c0_ack     (bm_ack),
		.c0_rdata   (bm_rdata),
		.c1_req     (sp_req),
		.c1_addr    (sp_addr),
		.c1_ack     (sp_ack),
		.c1_rdata   (sp_rdata),
		.dram_req   (dram_req),
		.dram_addr  (dram_addr),
		.dram_ack   (dram_ack),
		.dram_rdata (dram_rdata)
	);

	video_linebuf video_linebuf (
		.clk        (clk),
		.reset      (reset),
		.line_start (line_start),
		.bm_wr      (bm_wr),
		.sp_wr      (sp_wr),
		.de         (de),
		.col        (col),
		.border     (cfg.border),
		.pixel      (pixel)
	);

	// aligned with the registered pixel
	always_ff @(posedge clk) begin
		if (reset) begin
			pixel_de <= 1'b0;
		end else begin
			pixel_de <= de;
		end
	end

endmodule

/* sim/tb_clock.sv */
`timescale 1ns/1ns

module tb_clock (
	output logic clk,
	output logic reset
);

	localparam int HALF_PERIOD  = 2;
	localparam int RESET_CYCLES = 3;

	initial begin
		clk = 1'b0;
		forever begin
			#HALF_PERIOD clk = ~clk;
		end
	end

	// reset released on a rising edge
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) begin
			@(posedge clk);
		end
		reset <= 1'b0;
	end

endmodule

/* sim/video_asserts.sv */
`timescale 1ns/1ns

module video_asserts import video_pkg::*; (
	input logic       clk,
	input logic       reset,
	input logic       c0_req,
	input logic       c0_ack,
	input logic       c1_req,
	input logic       c1_ack,
	input logic       dram_req,
	input dram_addr_t dram_addr,
	input logic       dram_ack
);

	int fail_count = 0;

	// a request stays up until answered
	dram_req_held: assert property (@(posedge clk) disable iff (reset)
		dram_req && !dram_ack |=> dram_req)
		else begin
			fail_count = fail_count + 1;
			$error("dram_req dropped before dram_ack");
		end

	c0_req_held: assert property (@(posedge clk) disable iff (reset)
		c0_req && !c0_ack |=> c0_req)
		else begin
			fail_count = fail_count + 1;
			$error("fetcher req dropped before its ack");
		end

	c1_req_held: assert property (@(posedge clk) disable iff (reset)
		c1_req && !c1_ack |=> c1_req)
		else begin
			fail_count = fail_count + 1;
			$error("sprite engine req dropped before its ack");
		end

	// ack only falls once req is gone
	dram_ack_held: assert property (@(posedge clk) disable iff (reset)
		dram_ack && dram_req |=> dram_ack)
		else begin
			fail_count = fail_count + 1;
			$error("dram_ack fell while dram_req was still high");
		end

	dram_addr_stable: assert property (@(posedge clk) disable iff (reset)
		$past(dram_req) && dram_req |-> $stable(dram_addr))
		else begin
			fail_count = fail_count + 1;
			$error("dram_addr changed during a request");
		end

	// an ack only reaches the client that asked for it
	c0_ack_routed: assert property (@(posedge clk) disable iff (reset)
		$rose(c0_ack) |-> c0_req)
		else begin
			fail_count = fail_count + 1;
			$error("fetcher ack raised without a fetcher request");
		end

	c1_ack_routed: assert property (@(posedge clk) disable iff (reset)
		$rose(c1_ack) |-> c1_req)
		else begin
			fail_count = fail_count + 1;
			$error("sprite engine ack raised without a sprite request");
		end

endmodule

/* sim/video_tb.sv */
`timescale 1ns/1ns

module video_tb import video_pkg::*; ();

	localparam int FRAMES         = 4;
	localparam int TIMEOUT_MARGIN = 424;
	localparam int TIMEOUT_CYCLES = FRAMES * V_TOTAL * H_TOTAL + TIMEOUT_MARGIN;
	localparam int CHECKED_PIXELS = (FRAMES - 1) * V_ACTIVE * H_ACTIVE;
	localparam int CFG_LINE       = 9;
	localparam int RAND_SEED      = 4;
	localparam int MEM_WORDS      = 65536;
	localparam int DELAY_SLOTS    = 1024;

	logic       clk;
	logic       reset;
	logic       cfg_wr = 1'b0;
	cfg_addr_t  cfg_addr = '0;
	pixel_t     cfg_data = '0;
	logic       dram_req;
	dram_addr_t dram_addr;
	logic       dram_ack = 1'b0;
	dram_data_t dram_rdata = '0;
	logic       hsync;
	logic       vsync;
	logic       pixel_de;
	pixel_t     pixel;

	// DRAM model state
	dram_data_t mem [0:MEM_WORDS-1];
	int         delay_tab [0:DELAY_SLOTS-1];
	logic       busy;
	int         wait_cnt;
	int         req_num;

	// expected timing, config and output register
	int     h;
	int     l;
	int     frame;
	cfg_t   exp_cfg;
	logic   de_q;
	pixel_t border_q;
	int     row_q;
	int     col_q;
	int     pix_checks = 0;
	int     cycles = 0;

	tb_clock clock_gen (
		.clk   (clk),
		.reset (reset)
	);

	video_top uut (
		.clk        (clk),
		.reset      (reset),
		.cfg_wr     (cfg_wr),
		.cfg_addr   (cfg_addr),
		.cfg_data   (cfg_data),
		.dram_req   (dram_req),
		.dram_addr  (dram_addr),
		.dram_ack   (dram_ack),
		.dram_rdata (dram_rdata),
		.hsync      (hsync),
		.vsync      (vsync),
		.pixel_de   (pixel_de),
		.pixel      (pixel)
	);

	bind dram_arbiter video_asserts hs_checks (
		.clk       (clk),
		.reset     (reset),
		.c0_req    (c0_req),
		.c0_ack    (c0_ack),
		.c1_req    (c1_req),
		.c1_ack    (c1_ack),
		.dram_req  (dram_req),
		.dram_addr (dram_addr),
		.dram_ack  (dram_ack)
	);

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("SIMULATION FAILED");
		$fatal(1);
	endtask

	task automatic check_pixel(input string what, input pixel_t got, input pixel_t exp);
		if (got !== exp) begin
			abort_run($sformatf("ERR pixel (%s) got 0x%h exp 0x%h at frame %0d row %0d col %0d",
				what, got, exp, frame, row_q, col_q));
		end
	endtask

	task automatic check_sync(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			abort_run($sformatf("ERR %s got 0x%h exp 0x%h at frame %0d line %0d count %0d",
				name, got, exp, frame, l, h));
		end
	endtask

	function automatic dram_data_t desc_word(input int y, input int x);
		return dram_data_t'(32'h8000 | (y << 8) | x);
	endfunction

	// expected pixel from memory layout, sprites drawn in index order
	function automatic pixel_t ref_pixel(input page_t vpage, input page_t sgpage,
		input int row, input int col);
		int         base;
		int         spr;
		int         y;
		int         x;
		dram_data_t word;
		dram_data_t desc;
		pixel_t     pix;
		pixel_t     spix;
		base = int'(vpage) * PAGE_WORDS;
		word = mem[base + row * LINE_WORDS + col / 2];
		pix = (col % 2) ? word[15:8] : word[7:0];
		base = int'(sgpage) * PAGE_WORDS;
		for (spr = 0; spr < SPR_NUM; spr++) begin
			desc = mem[base + spr];
			y = int'(desc[12:8]);
			x = int'(desc[4:0]);
			if (desc[15] && row >= y && row < y + SPR_SIZE && col >= x && col < x + SPR_SIZE) begin
				word = mem[base + SPR_PIX_OFFS + spr * SPR_SIZE * 4 + (row - y) * 4
					+ (col - x) / 2];
				spix = ((col - x) % 2) ? word[15:8] : word[7:0];
				if (spix != '0) begin
					pix = spix;
				end
			end
		end
		return pix;
	endfunction

	task automatic prepare_memory();
		int seed_val;
		int i;
		int k;
		int w;
		int a;
		seed_val = $urandom(RAND_SEED);
		for (i = 0; i < MEM_WORDS; i++) begin
			mem[i] = dram_data_t'($urandom);
		end
		for (i = 0; i < DELAY_SLOTS; i++) begin
			delay_tab[i] = $urandom_range(4, 1);
		end
		// page 2 holds four disabled descriptors
		for (i = 0; i < SPR_NUM; i++) begin
			mem[2 * PAGE_WORDS + i][15] = 1'b0;
		end
		// page 4: overlapping sprites, one clipped right, one low on screen
		mem[4 * PAGE_WORDS + 0] = desc_word(1, 4);
		mem[4 * PAGE_WORDS + 1] = desc_word(3, 8);
		mem[4 * PAGE_WORDS + 2] = desc_word(6, 28);
		mem[4 * PAGE_WORDS + 3] = desc_word(2, 6);
		// holes in sprites 1 and 3
		for (i = 1; i < SPR_NUM; i += 2) begin
			for (k = 0; k < SPR_SIZE; k++) begin
				for (w = 0; w < 4; w++) begin
					a = 4 * PAGE_WORDS + SPR_PIX_OFFS + i * SPR_SIZE * 4 + k * 4 + w;
					if ((k + w) % 2) begin
						mem[a][7:0] = '0;
					end else begin
						mem[a][15:8] = '0;
					end
				end
			end
		end
		// page 9: random placements that reach the screen
		for (i = 0; i < SPR_NUM; i++) begin
			mem[9 * PAGE_WORDS + i] = desc_word($urandom % 8, $urandom % 32);
		end
	endtask

	task automatic write_cfg(input cfg_addr_t addr, input pixel_t data);
		cfg_wr <= 1'b1;
		cfg_addr <= addr;
		cfg_data <= data;
		@(posedge clk);
	endtask

	// waits for vertical blank, then sets up the following frame
	task automatic program_next_frame(input page_t vp, input page_t sp, input pixel_t bd);
		@(posedge clk);
		while (!(l == CFG_LINE && h == 0)) begin
			@(posedge clk);
		end
		write_cfg(2'd0, vp);
		write_cfg(2'd1, sp);
		write_cfg(2'd2, bd);
		cfg_wr <= 1'b0;
	endtask

	// DRAM answers after 1 to 4 cycles, four-phase
	always @(posedge clk) begin
		if (reset) begin
			dram_ack <= 1'b0;
			busy <= 1'b0;
			wait_cnt <= 0;
			req_num <= 0;
		end else if (dram_ack) begin
			if (!dram_req) begin
				dram_ack <= 1'b0;
			end
		end else if (busy) begin
			if (wait_cnt <= 1) begin
				dram_ack <= 1'b1;
				dram_rdata <= mem[dram_addr[15:0]];
				busy <= 1'b0;
			end else begin
				wait_cnt <= wait_cnt - 1;
			end
		end else if (dram_req) begin
			busy <= 1'b1;
			wait_cnt <= delay_tab[req_num % DELAY_SLOTS];
			req_num <= req_num + 1;
		end
	end

	// line and count from reset, register file and output stage
	always @(posedge clk) begin
		if (reset) begin
			h <= 0;
			l <= 0;
			frame <= 0;
			exp_cfg <= '0;
			de_q <= 1'b0;
			border_q <= '0;
			row_q <= 0;
			col_q <= 0;
		end else begin
			if (h == H_TOTAL - 1) begin
				h <= 0;
				l <= (l == V_TOTAL - 1) ? 0 : l + 1;
				if (l == V_TOTAL - 1) begin
					frame <= frame + 1;
				end
			end else begin
				h <= h + 1;
			end
			de_q <= (h >= H_PIX_BEG) && (h < H_PIX_BEG + H_ACTIVE) && (l < V_ACTIVE);
			row_q <= l;
			col_q <= h - H_PIX_BEG;
			border_q <= exp_cfg.border;
			if (cfg_wr) begin
				case (cfg_addr)
					2'd0: exp_cfg.vpage <= cfg_data;
					2'd1: exp_cfg.sgpage <= cfg_data;
					2'd2: exp_cfg.border <= cfg_data;
					default: exp_cfg <= exp_cfg;
				endcase
			end
		end
	end

	// compare on the falling edge
	always @(negedge clk) begin
		if (!reset) begin
			check_sync("hsync", hsync, h < H_SYNC);
			check_sync("vsync", vsync, l >= V_SYNC_BEG);
			check_sync("pixel_de", pixel_de, de_q);
			if (!de_q) begin
				check_pixel("border", pixel, border_q);
			end else if (frame > 0) begin
				// row 0 of frame 0 is never rendered
				check_pixel("active", pixel,
					ref_pixel(exp_cfg.vpage, exp_cfg.sgpage, row_q, col_q));
				pix_checks++;
			end
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			abort_run($sformatf("timeout: run did not complete within %0d cycles",
				TIMEOUT_CYCLES));
		end else if (uut.dram_arbiter.hs_checks.fail_count != 0) begin
			abort_run("a handshake assertion on the DRAM arbiter failed");
		end
	end

	initial begin
		prepare_memory();
		while (reset !== 1'b0) begin
			@(posedge clk);
		end
		// bitmap only, then sprite overlay, then new pages and border
		program_next_frame(8'd1, 8'd2, 8'h5a);
		program_next_frame(8'd3, 8'd4, 8'hc3);
		program_next_frame(8'd5, 8'd9, 8'h0f);
		while (frame < FRAMES) begin
			@(posedge clk);
		end
		if (pix_checks == CHECKED_PIXELS) begin
			$display("SIMULATION PASSED");
			$finish;
		end else begin
			abort_run($sformatf("only %0d of %0d active pixels were compared",
				pix_checks, CHECKED_PIXELS));
		end
	end

endmodule

/* tb.f */
source/video_pkg.sv
source/video_ports.sv
source/video_sync.sv
source/video_fetch.sv
source/video_sprites.sv
source/dram_arbiter.sv
source/video_linebuf.sv
source/video_top.sv
sim/tb_clock.sv
sim/video_asserts.sv
sim/video_tb.sv

/* Bender.yml */
package:
  name: video_subsystem

sources:
  - source/video_pkg.sv
  - source/video_ports.sv
  - source/video_sync.sv
  - source/video_fetch.sv
  - source/video_sprites.sv
  - source/dram_arbiter.sv
  - source/video_linebuf.sv
  - source/video_top.sv
  - target: simulation
    files:
      - sim/tb_clock.sv
      - sim/video_asserts.sv
      - sim/video_tb.sv
